// ==== rtl/usbTxPkg.sv ====
package usbTxPkg;

    // ==============================
    // Packet identifiers
    // ==============================

    // Only the four PID bits are stored here
    // The check nibble on the wire is their complement and comes from the host byte
    // The two low bits select the packet class
    typedef enum logic [3:0] {
        PidOut   = 4'b0001,
        PidIn    = 4'b1001,
        PidSof   = 4'b0101,
        PidSetup = 4'b1101,
        PidData0 = 4'b0011,
        PidData1 = 4'b1011,
        PidAck   = 4'b0010,
        PidNak   = 4'b1010,
        PidStall = 4'b1110,
        PidPre   = 4'b1100
    } pidType;

    // Packet class codes taken from the PID low bits
    localparam logic [1:0] classToken     = 2'b01;
    localparam logic [1:0] classData      = 2'b11;
    localparam logic [1:0] classHandshake = 2'b10;
    localparam logic [1:0] classSpecial   = 2'b00;

    // ==============================
    // Line constants
    // ==============================

    // Sent LSB first this gives seven zeros and a closing one (KJKJKJKK)
    localparam logic [7:0] syncValue = 8'h80;

    // Generator polynomials in normal form without the top term
    localparam logic [4:0]  crc5Poly     = 5'b00101;
    localparam logic [15:0] crc16Poly    = 16'h8005;
    // Register value left after a good payload plus its transmitted CRC16
    localparam logic [15:0] crc16Residue = 16'h800D;

    // One byte of the host stream with its end-of-packet marker
    typedef struct packed {
        logic [7:0] data;
        logic       isLast;
    } txByteT;

    // Differential pair as driven onto the bus
    typedef struct packed {
        logic dp;
        logic dn;
    } lineStateT;

endpackage

// ==== rtl/outputShiftReg.sv ====
`timescale 1ns/1ps

module outputShiftReg (
    input  logic       clk48,
    input  logic       rstN,
    input  logic       bitEn,
    input  logic       hold,
    input  logic       loadByte,
    input  logic [7:0] dataIn,
    output logic       bitOut,
    output logic       bufferEmpty
);

    logic [7:0] shiftReg;
    // Index of the bit now on bitOut
    logic [2:0] bitCnt;

    assign bitOut = shiftReg[0];

    // The last bit of the byte is out, so a new byte may load on this strobe
    assign bufferEmpty = bitCnt == 3'd7;

    // Bit counter stays at seven once the byte is used up and waits for a load
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            bitCnt <= 3'd7;
        end else if (bitEn && !hold) begin
            if (loadByte) begin
                bitCnt <= 3'd0;
            end else if (!bufferEmpty) begin
                bitCnt <= bitCnt + 3'd1;
            end
        end
    end

    // Shift right so that the LSB leaves first, zeros fill in behind
    always_ff @(posedge clk48) begin
        if (bitEn && !hold) begin
            shiftReg <= loadByte ? dataIn : {1'b0, shiftReg[7:1]};
        end
    end

    // The packet FSM must only hand over a byte when the previous one is spent
    loadOnlyWhenEmpty: assert property (@(posedge clk48) disable iff (!rstN)
        loadByte |-> bufferEmpty)
        else $error("Serializer loaded while a byte was still in flight");

endmodule

// ==== rtl/usbCrc.sv ====
`timescale 1ns/1ps

module usbCrc (
    input  logic        clk48,
    input  logic        rstN,
    input  logic        clear,
    input  logic        bitEn,
    input  logic        ready,
    input  logic        useCrc16,
    input  logic        dataBit,
    output logic [15:0] crcOut
);
    import usbTxPkg::*;

    logic [15:0] crcReg;
    logic [15:0] stepVal;
    logic [15:0] nextCrc;
    logic [15:0] revCrc;
    logic        feedback;

    // One LFSR step, CRC5 lives in the low five bits of the same register
    always_comb begin
        if (useCrc16) begin
            feedback = dataBit ^ crcReg[15];
            stepVal = {crcReg[14:0], 1'b0} ^ (feedback ? crc16Poly : 16'h0000);
        end else begin
            feedback = dataBit ^ crcReg[4];
            stepVal = {11'h000, crcReg[3:0], 1'b0} ^
                      (feedback ? {11'h000, crc5Poly} : 16'h0000);
        end
    end

    // Clear presets to all ones
    // Stuffed bits never reach the LFSR because ready is low for them
    always_comb begin
        if (clear) begin
            nextCrc = 16'hFFFF;
        end else if (bitEn && ready) begin
            nextCrc = stepVal;
        end else begin
            nextCrc = crcReg;
        end
    end

    // The output looks ahead to the bit under the strobe
    // That lets the FSM load the CRC byte on the same strobe as the last data bit
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            revCrc[i] = nextCrc[15 - i];
        end
    end

    // Remainder MSB goes out first, so bit zero of crcOut is the first wire bit
    assign crcOut = useCrc16 ? ~revCrc : {11'h000, ~revCrc[15:11]};

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            crcReg <= 16'hFFFF;
        end else begin
            crcReg <= nextCrc;
        end
    end

endmodule

// ==== rtl/bitStuffer.sv ====
`timescale 1ns/1ps

module bitStuffer (
    input  logic clk48,
    input  logic rstN,
    input  logic bitEn,
    input  logic restart,
    input  logic dataBit,
    output logic ready,
    output logic stuffedBit
);

    // Run length of ones already placed on the wire
    logic [2:0] onesCnt;

    // Six ones in a row means this bit period carries the stuffed zero
    assign ready = onesCnt != 3'd6;

    // During a stuffed period the data bit waits in the serializer
    assign stuffedBit = ready & dataBit;

    // Counting is on strobes only
    // The stuffed zero itself also ends the run
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            onesCnt <= 3'd0;
        end else if (restart) begin
            onesCnt <= 3'd0;
        end else if (bitEn) begin
            if (!ready || !dataBit) begin
                onesCnt <= 3'd0;
            end else begin
                onesCnt <= onesCnt + 3'd1;
            end
        end
    end

    // A seventh one would mean the serializer moved on during a stuffed bit
    onesNeverAboveSix: assert property (@(posedge clk48) disable iff (!rstN)
        onesCnt <= 3'd6)
        else $error("Ones run exceeded six without a stuffed zero");

endmodule

// ==== rtl/usbTx.sv ====
`timescale 1ns/1ps

module usbTx #(
    parameter int BitDivide = 4
) (
    input  logic                clk48,
    input  logic                rstN,
    input  logic                txReqSendPacket,
    input  usbTxPkg::txByteT    txByte,
    input  logic                txDataValid,
    output logic                txAcceptNewData,
    output logic                sending,
    output usbTxPkg::lineStateT lineOut
);
    import usbTxPkg::*;

    localparam int DivWidth = $clog2(BitDivide);
    localparam logic [DivWidth-1:0] DivMax = DivWidth'(BitDivide - 1);
    localparam lineStateT LineJ = '{dp: 1'b1, dn: 1'b0};
    localparam lineStateT LineSe0 = '{dp: 1'b0, dn: 1'b0};

    // The transition state carries the low CRC16 byte, the next one the high byte
    typedef enum logic [3:0] {
        WaitReq,
        SendSync,
        SendPid,
        SendData,
        SendCrc16Trans,
        SendCrc16,
        SendCrc5,
        Eop1,
        Eop2,
        Eop3,
        EopEnd
    } txStateT;

    txStateT             txState;
    txStateT             nextState;
    pidType              txPid;
    txByteT              bufByte;
    logic                bufFull;
    logic                curLast;
    logic                loadFromBuf;
    logic [DivWidth-1:0] divCnt;
    logic                bitEn;
    logic                adv;
    logic                byteDone;
    logic                loadByte;
    logic [7:0]          serIn;
    logic                serBit;
    logic                bufferEmpty;
    logic                stuffReady;
    logic                stuffedBit;
    logic                txBit;
    logic [2:0]          patchCnt;
    logic [2:0]          patchIdx;
    logic                patching;
    logic                crcRun;
    logic [15:0]         crcOut;
    logic                pidIsData;
    logic                pidIsToken;
    logic                se0Now;
    logic                forceJ;
    logic                nrziLevel;
    logic                nrziNext;

    // ==============================
    // Byte buffer
    // ==============================

    assign txAcceptNewData = ~bufFull;

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            bufFull <= 1'b0;
        end else if (loadFromBuf) begin
            bufFull <= 1'b0;
        end else if (txDataValid && !bufFull) begin
            bufFull <= 1'b1;
        end
    end

    always_ff @(posedge clk48) begin
        if (txDataValid && !bufFull) begin
            bufByte <= txByte;
        end
    end

    // ==============================
    // Bit strobe
    // ==============================

    // Idle parks the divider at its top value
    // The request edge is then a strobe by itself and loads SYNC at once
    assign bitEn = (divCnt == DivMax) && (txState != WaitReq || txReqSendPacket);
    assign adv = bitEn && stuffReady;
    assign byteDone = adv && bufferEmpty;

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            divCnt <= DivMax;
        end else if (bitEn) begin
            divCnt <= (txState == EopEnd) ? DivMax : '0;
        end else if (txState != WaitReq) begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // ==============================
    // Packet FSM
    // ==============================

    assign pidIsData = txPid[1:0] == classData;
    assign pidIsToken = txPid[1:0] == classToken;

    always_comb begin
        nextState = txState;
        loadByte = 1'b0;
        loadFromBuf = 1'b0;
        serIn = bufByte.data;
        unique case (txState)
            WaitReq: begin
                if (bitEn) begin
                    loadByte = 1'b1;
                    serIn = syncValue;
                    nextState = SendSync;
                end
            end
            SendSync: begin
                // The PID byte is in the buffer by now
                if (byteDone) begin
                    loadByte = 1'b1;
                    loadFromBuf = 1'b1;
                    nextState = SendPid;
                end
            end
            SendPid, SendData: begin
                if (byteDone) begin
                    if (txState == SendPid && !pidIsData && !pidIsToken) begin
                        nextState = Eop1;
                    end else if (pidIsData && curLast) begin
                        loadByte = 1'b1;
                        serIn = crcOut[7:0];
                        nextState = SendCrc16Trans;
                    end else begin
                        // The last token byte goes out whole and gets patched on the fly
                        loadByte = 1'b1;
                        loadFromBuf = 1'b1;
                        nextState = (pidIsToken && bufByte.isLast) ? SendCrc5 : SendData;
                    end
                end
            end
            SendCrc16Trans: begin
                if (byteDone) begin
                    loadByte = 1'b1;
                    serIn = crcOut[15:8];
                    nextState = SendCrc16;
                end
            end
            SendCrc16, SendCrc5: begin
                if (byteDone) begin
                    nextState = Eop1;
                end
            end
            Eop1: begin
                // Stay one more bit if a stuffed zero is still owed
                if (bitEn && stuffReady) begin
                    nextState = Eop2;
                end
            end
            Eop2: begin
                if (bitEn) begin
                    nextState = Eop3;
                end
            end
            Eop3: begin
                if (bitEn) begin
                    nextState = EopEnd;
                end
            end
            EopEnd: begin
                if (bitEn) begin
                    nextState = WaitReq;
                end
            end
            default: begin
                nextState = WaitReq;
            end
        endcase
    end

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            txState <= WaitReq;
            txPid <= PidAck;
            curLast <= 1'b0;
            patchCnt <= 3'd0;
        end else begin
            txState <= nextState;
            if (loadFromBuf) begin
                curLast <= bufByte.isLast;
            end
            if (loadFromBuf && txState == SendSync) begin
                txPid <= pidType'(bufByte.data[3:0]);
            end
            if (loadByte) begin
                patchCnt <= 3'd0;
            end else if (adv) begin
                patchCnt <= patchCnt + 3'd1;
            end
        end
    end

    // ==============================
    // CRC patching and line output
    // ==============================

    // Bits three to seven of the last token byte are replaced by the frozen CRC5
    assign patching = txState == SendCrc5 && patchCnt >= 3'd3;
    assign patchIdx = patchCnt - 3'd3;
    assign txBit = patching ? crcOut[patchIdx] : serBit;
    assign crcRun = txState == SendData || (txState == SendCrc5 && !patching);

    assign se0Now = (txState == Eop1 && stuffReady) || txState == Eop2;
    assign forceJ = txState == WaitReq || txState == Eop3 || txState == EopEnd;

    // NRZI toggles on a zero and keeps the level on a one
    always_comb begin
        if (forceJ) begin
            nrziNext = 1'b1;
        end else if (se0Now) begin
            nrziNext = nrziLevel;
        end else begin
            nrziNext = nrziLevel ^ ~stuffedBit;
        end
    end

    // Line and sending move together, one bit behind the serializer
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            nrziLevel <= 1'b1;
            lineOut <= LineJ;
            sending <= 1'b0;
        end else if (bitEn) begin
            nrziLevel <= nrziNext;
            lineOut <= se0Now ? LineSe0 : '{dp: nrziNext, dn: ~nrziNext};
            sending <= txState != WaitReq && txState != EopEnd;
        end
    end

    outputShiftReg serializer (
        .clk48      (clk48),
        .rstN       (rstN),
        .bitEn      (bitEn),
        .hold       (!stuffReady),
        .loadByte   (loadByte),
        .dataIn     (serIn),
        .bitOut     (serBit),
        .bufferEmpty(bufferEmpty)
    );

    usbCrc crcGen (
        .clk48   (clk48),
        .rstN    (rstN),
        .clear   (txState == SendPid),
        .bitEn   (bitEn),
        .ready   (stuffReady && crcRun),
        .useCrc16(pidIsData),
        .dataBit (txBit),
        .crcOut  (crcOut)
    );

    bitStuffer stuffer (
        .clk48     (clk48),
        .rstN      (rstN),
        .bitEn     (bitEn),
        .restart   (txState == WaitReq),
        .dataBit   (txBit),
        .ready     (stuffReady),
        .stuffedBit(stuffedBit)
    );

    // The host must keep the buffer filled while a packet still wants bytes
    noByteUnderrun: assert property (@(posedge clk48) disable iff (!rstN)
        loadFromBuf |-> bufFull)
        else $error("Byte underrun while the packet was on the wire");

    noSe1: assert property (@(posedge clk48) disable iff (!rstN)
        !(lineOut.dp && lineOut.dn))
        else $error("Line drove SE1");

    sendingEndsInEop: assert property (@(posedge clk48) disable iff (!rstN)
        $fell(sending) |-> $past(txState) == EopEnd)
        else $error("sending fell before the EOP was complete");

endmodule

// ==== rtl/usbTxTop.sv ====
`timescale 1ns/1ps

module usbTxTop #(
    // Clock cycles per wire bit, four gives full speed from 48 MHz
    parameter int BitDivide = 4
) (
    input  logic                clk48,
    input  logic                rstN,
    // Starts a packet when seen in idle
    input  logic                txReqSendPacket,
    // PID first, then payload, the last byte flagged
    input  usbTxPkg::txByteT    txByte,
    input  logic                txDataValid,
    output logic                txAcceptNewData,
    // High from the first SYNC bit through the closing J
    output logic                sending,
    output usbTxPkg::lineStateT lineOut
);

    // ==============================
    // Elaboration check
    // ==============================

    // One cycle per bit leaves no room for the strobe
    if (BitDivide < 2) begin : gDivideCheck
        $error("BitDivide must be two or more");
    end

    // ==============================
    // Transmitter
    // ==============================

    usbTx #(
        .BitDivide(BitDivide)
    ) tx (
        .clk48          (clk48),
        .rstN           (rstN),
        .txReqSendPacket(txReqSendPacket),
        .txByte         (txByte),
        .txDataValid    (txDataValid),
        .txAcceptNewData(txAcceptNewData),
        .sending        (sending),
        .lineOut        (lineOut)
    );

endmodule

// ==== test/usbLineMonitor.sv ====
`timescale 1ns/1ps

module usbLineMonitor #(
    // Clock cycles per wire bit as the testbench expects it
    parameter int BitDivide = 4
) (
    input  logic                clk48,
    input  logic                rstN,
    input  usbTxPkg::lineStateT lineOut,
    // High for every clock of a packet, from the first K through the closing J
    output logic                inPacket,
    output int                  pktCount,
    output int                  rxCount,
    output logic [7:0]          rxBytes [16],
    output logic                frameOk,
    output logic                stuffOk,
    output logic                eopOk,
    output logic                crcOk,
    output logic                eopStuffSeen
);
    import usbTxPkg::*;

    localparam lineStateT LineJ = '{dp: 1'b1, dn: 1'b0};

    // Where the decoder stands within a packet
    typedef enum {
        Idle,
        Bits,
        Se0One,
        Se0Two,
        Tail
    } monStateT;

    monStateT monState;
    logic     bitQ [$];
    int       phase;
    int       onesRun;
    logic     prevLevel;
    logic     lastStuffed;

    // ==============================
    // Reference CRC
    // ==============================

    // Textbook serial LFSR, the wide flag picks CRC16 over CRC5
    function automatic logic [15:0] crcShift(input logic [15:0] crc, input logic b,
                                             input logic wide);
        logic fb;
        if (wide) begin
            fb = b ^ crc[15];
            crcShift = {crc[14:0], 1'b0} ^ (fb ? crc16Poly : 16'h0000);
        end else begin
            fb = b ^ crc[4];
            crcShift = {11'h000, crc[3:0], 1'b0} ^ (fb ? {11'h000, crc5Poly} : 16'h0000);
        end
    endfunction

    // ==============================
    // Bit decoding
    // ==============================

    // NRZI back to data, then drop the zero that follows six ones
    task automatic takeBit(input lineStateT ls);
        logic b;
        b = ls.dp == prevLevel;
        prevLevel = ls.dp;
        if (onesRun == 6 && !b) begin
            onesRun = 0;
            lastStuffed = 1'b1;
        end else begin
            // A one here would be the seventh in a row
            if (onesRun == 6) begin
                stuffOk = 1'b0;
            end
            bitQ.push_back(b);
            onesRun = b ? onesRun + 1 : 0;
            lastStuffed = 1'b0;
        end
    endtask

    // Rebuild bytes, check SYNC and run the CRC of the packet class
    task automatic closePacket();
        int          nBits;
        logic [15:0] crc;
        logic [7:0]  pid;
        nBits = bitQ.size();
        frameOk = nBits >= 16 && nBits % 8 == 0 && nBits <= 136;
        rxCount = frameOk ? nBits / 8 - 1 : 0;
        if (frameOk) begin
            for (int k = 0; k < 8; k++) begin
                frameOk = frameOk && bitQ[k] == syncValue[k];
            end
        end
        for (int k = 0; k < rxCount; k++) begin
            for (int j = 0; j < 8; j++) begin
                rxBytes[k][j] = bitQ[8 * k + 8 + j];
            end
        end
        pid = rxBytes[0];
        crcOk = frameOk;
        if (frameOk && pid[1:0] == classToken) begin
            // Eleven address and endpoint bits, then five CRC bits sent MSB first
            crcOk = nBits == 32;
            if (crcOk) begin
                crc = 16'h001F;
                for (int i = 16; i < 27; i++) begin
                    crc = crcShift(crc, bitQ[i], 1'b0);
                end
                for (int i = 0; i < 5; i++) begin
                    crcOk = crcOk && bitQ[27 + i] == ~crc[4 - i];
                end
            end
        end else if (frameOk && pid[1:0] == classData) begin
            crc = 16'hFFFF;
            for (int i = 16; i < nBits; i++) begin
                crc = crcShift(crc, bitQ[i], 1'b1);
            end
            crcOk = nBits >= 32 && crc == crc16Residue;
        end
        bitQ.delete();
        pktCount++;
    endtask

    // One sample per wire bit, roughly in the middle of the bit
    task automatic sampleBit();
        logic isSe0;
        isSe0 = !lineOut.dp && !lineOut.dn;
        case (monState)
            Bits: begin
                if (isSe0) begin
                    // A run of six must be broken before the EOP starts
                    if (onesRun == 6) begin
                        stuffOk = 1'b0;
                    end
                    eopStuffSeen = lastStuffed;
                    monState = Se0One;
                end else begin
                    takeBit(lineOut);
                end
            end
            Se0One: begin
                eopOk = eopOk && isSe0;
                monState = Se0Two;
            end
            default: begin
                eopOk = eopOk && lineOut == LineJ;
                closePacket();
                phase = 0;
                monState = Tail;
            end
        endcase
    endtask

    always @(negedge clk48 or negedge rstN) begin
        if (!rstN) begin
            monState = Idle;
            inPacket = 1'b0;
            pktCount = 0;
            rxCount = 0;
            frameOk = 1'b0;
            stuffOk = 1'b1;
            eopOk = 1'b1;
            crcOk = 1'b0;
            eopStuffSeen = 1'b0;
            phase = 0;
            onesRun = 0;
            prevLevel = 1'b1;
            lastStuffed = 1'b0;
            bitQ.delete();
        end else begin
            case (monState)
                Idle: begin
                    // The first K of SYNC starts the packet and sets the bit phase
                    if (lineOut != LineJ) begin
                        inPacket = 1'b1;
                        stuffOk = 1'b1;
                        eopOk = 1'b1;
                        eopStuffSeen = 1'b0;
                        onesRun = 0;
                        prevLevel = 1'b1;
                        lastStuffed = 1'b0;
                        phase = 0;
                        monState = Bits;
                        takeBit(lineOut);
                    end
                end
                Tail: begin
                    // The closing J still belongs to the packet until its bit ends
                    phase++;
                    if (phase == BitDivide) begin
                        inPacket = 1'b0;
                        monState = Idle;
                    end
                end
                default: begin
                    phase++;
                    if (phase == BitDivide) begin
                        phase = 0;
                        sampleBit();
                    end
                end
            endcase
        end
    end

endmodule

// ==== test/usbTxTb.sv ====
`timescale 1ns/1ps

module usbTxTb;
    import usbTxPkg::*;

    localparam int BitDivide = 4;
    localparam int Rounds = 6;
    // Three packets per round, then the all-ones packet and the EOP stuffing packet
    localparam int NumPackets = Rounds * 3 + 2;
    // SYNC, PID, eight bytes and CRC16 with stuffing, EOP and the idle gap
    localparam int MaxPktBits = 160;
    localparam int WatchdogNs = NumPackets * MaxPktBits * BitDivide * 100 + 200000;
    localparam lineStateT LineJ = '{dp: 1'b1, dn: 1'b0};

    logic       clk48;
    logic       rstN;
    logic       txReqSendPacket;
    txByteT     txByte;
    logic       txDataValid;
    logic       txAcceptNewData;
    logic       sending;
    lineStateT  lineOut;
    logic       inPacket;
    int         pktCount;
    int         rxCount;
    logic [7:0] rxBytes [16];
    logic       frameOk;
    logic       stuffOk;
    logic       eopOk;
    logic       crcOk;
    logic       eopStuffSeen;
    int         errCount;
    int         checkCount;
    logic [7:0] txQ [$];

    usbTxTop #(
        .BitDivide(BitDivide)
    ) UUT (
        .clk48          (clk48),
        .rstN           (rstN),
        .txReqSendPacket(txReqSendPacket),
        .txByte         (txByte),
        .txDataValid    (txDataValid),
        .txAcceptNewData(txAcceptNewData),
        .sending        (sending),
        .lineOut        (lineOut)
    );

    usbLineMonitor #(
        .BitDivide(BitDivide)
    ) monitor (
        .clk48       (clk48),
        .rstN        (rstN),
        .lineOut     (lineOut),
        .inPacket    (inPacket),
        .pktCount    (pktCount),
        .rxCount     (rxCount),
        .rxBytes     (rxBytes),
        .frameOk     (frameOk),
        .stuffOk     (stuffOk),
        .eopOk       (eopOk),
        .crcOk       (crcOk),
        .eopStuffSeen(eopStuffSeen)
    );

    initial begin
        clk48 = 1'b0;
        forever #50 clk48 = ~clk48;
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout: the packets did not finish within %0d ns", WatchdogNs);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check(input logic cond, input string msg);
        checkCount++;
        assert (cond) else begin
            errCount++;
            $display("Fail at %0t: %s", $time, msg);
        end
    endtask

    // ==============================
    // Line checks on every clock
    // ==============================

    // Values seen here are the ones settled before this edge
    always @(posedge clk48) begin
        if (rstN) begin
            check(sending == inPacket, "sending does not match the packet on the line");
            if (!inPacket) begin
                check(lineOut == LineJ, "line is not J between packets");
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    function automatic logic [7:0] pidByte(input pidType pid);
        logic [3:0] code;
        code = pid;
        return {~code, code};
    endfunction

    // CRC16 remainder of a two-byte payload, bits in wire order
    function automatic logic [15:0] payloadCrc(input logic [15:0] payload);
        logic [15:0] crc;
        logic        fb;
        crc = 16'hFFFF;
        for (int i = 0; i < 16; i++) begin
            fb = payload[i] ^ crc[15];
            crc = {crc[14:0], 1'b0} ^ (fb ? crc16Poly : 16'h0000);
        end
        return crc;
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic offerByte(input logic [7:0] value, input logic last);
        txByte = '{data: value, isLast: last};
        txDataValid = 1'b1;
        while (!txAcceptNewData) begin
            @(negedge clk48);
        end
        @(negedge clk48);
        txDataValid = 1'b0;
    endtask

    // The PID byte goes into the buffer before the request is raised
    task automatic runPacket();
        int startCount;
        int waitCycles;
        startCount = pktCount;
        waitCycles = 0;
        @(negedge clk48);
        offerByte(txQ[0], txQ.size() == 1);
        txReqSendPacket = 1'b1;
        @(negedge clk48);
        txReqSendPacket = 1'b0;
        while (!sending) begin
            @(negedge clk48);
            waitCycles++;
        end
        check(waitCycles <= BitDivide + 2, "sending rose too late after the request");
        for (int i = 1; i < txQ.size(); i++) begin
            offerByte(txQ[i], i == txQ.size() - 1);
        end
        while (pktCount == startCount) begin
            @(posedge clk48);
        end
        while (sending) begin
            @(negedge clk48);
        end
    endtask

    task automatic checkPacket(input logic wantEopStuff);
        logic [1:0] cls;
        logic [7:0] mask;
        int         extra;
        cls = txQ[0][1:0];
        extra = (cls == classData) ? 2 : 0;
        check(frameOk, "SYNC or byte framing is wrong");
        check(stuffOk, "bit stuffing is wrong on the line");
        check(eopOk, "EOP was not two SE0 bits and a J");
        check(crcOk, "CRC does not match the payload");
        check(rxCount == txQ.size() + extra,
              $sformatf("got %0d bytes, expected %0d", rxCount, txQ.size() + extra));
        for (int i = 0; i < txQ.size() && i < rxCount; i++) begin
            // The top five bits of the last token byte carry the CRC5
            mask = (cls == classToken && i == txQ.size() - 1) ? 8'h07 : 8'hFF;
            check((rxBytes[i] & mask) == (txQ[i] & mask),
                  $sformatf("byte %0d is %h, expected %h", i, rxBytes[i], txQ[i]));
        end
        if (wantEopStuff) begin
            check(eopStuffSeen, "no stuffed zero just before the EOP");
        end
    endtask

    task automatic sendHandshake(input pidType pid);
        txQ.delete();
        txQ.push_back(pidByte(pid));
        runPacket();
        checkPacket(1'b0);
    endtask

    task automatic sendToken(input pidType pid);
        logic [10:0] field;
        field = 11'($urandom);
        txQ.delete();
        txQ.push_back(pidByte(pid));
        txQ.push_back(field[7:0]);
        txQ.push_back({5'b00000, field[10:8]});
        runPacket();
        checkPacket(1'b0);
    endtask

    task automatic sendData(input pidType pid, input int len, input logic allOnes);
        txQ.delete();
        txQ.push_back(pidByte(pid));
        for (int i = 0; i < len; i++) begin
            txQ.push_back(allOnes ? 8'hFF : 8'($urandom));
        end
        runPacket();
        checkPacket(1'b0);
    endtask

    // Wire bit k of the CRC16 is the inverse of remainder bit 15-k
    // Remainder bits 6 to 0 of 1000000 end the packet with a zero and six ones
    task automatic sendEopStuffPacket();
        logic [15:0] payload;
        logic [15:0] start;
        start = 16'($urandom);
        payload = start;
        for (int v = 0; v < 65536; v++) begin
            payload = start + 16'(v);
            if (payloadCrc(payload)[6:0] == 7'b1000000) begin
                break;
            end
        end
        txQ.delete();
        txQ.push_back(pidByte(PidData1));
        txQ.push_back(payload[7:0]);
        txQ.push_back(payload[15:8]);
        runPacket();
        checkPacket(1'b1);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        errCount = 0;
        checkCount = 0;
        rstN = 1'b0;
        txReqSendPacket = 1'b0;
        txByte = '0;
        txDataValid = 1'b0;
        void'($urandom(32'h938d_14b4));
        repeat (3) @(posedge clk48);
        @(negedge clk48);
        rstN = 1'b1;

        // Idle line before the first request
        repeat (4) begin
            @(negedge clk48);
            check(lineOut == LineJ && !sending && txAcceptNewData,
                  "idle outputs after reset are wrong");
        end

        for (int r = 0; r < Rounds; r++) begin
            sendHandshake((r % 2 == 1) ? PidNak : PidAck);
            sendToken((r % 3 == 0) ? PidIn : ((r % 3 == 1) ? PidOut : PidSetup));
            sendData((r % 2 == 1) ? PidData1 : PidData0,
                     (r == 0) ? 0 : int'($urandom_range(8, 0)), 1'b0);
        end
        sendData(PidData0, 8, 1'b1);
        sendEopStuffPacket();

        repeat (2 * BitDivide) @(negedge clk48);
        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/usbTxPkg.sv
rtl/outputShiftReg.sv
rtl/usbCrc.sv
rtl/bitStuffer.sv
rtl/usbTx.sv
rtl/usbTxTop.sv
test/usbLineMonitor.sv
test/usbTxTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing --assert -Wno-fatal --top-module usbTxTb \
    -f sources.f -o usbTxSim &&
./obj_dir/usbTxSim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
